// ==== Makefile ====
# Verilator build and run for the cache testbench
VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/cache_tb.sv ====
// testbench for cache_top with a random-stall memory and a reference memory
// memory word i starts as lcg(i); all inputs change on the falling edge
// the reference memory is updated when a store response is taken
`timescale 1ns/1ps

module cache_tb;
  import cache_pkg::*;

  localparam int timeout_c = 4000;

  logic        clk_i, reset_i, v_i, we_i, yumi_i;
  addr_t       addr_i;
  word_t       wdata_i, data_o, mem_rdata_i, mem_wdata_o;
  logic        yumi_o, v_o, mem_cmd_v_o, mem_cmd_write_o, mem_cmd_yumi_i;
  block_addr_t mem_cmd_addr_o;
  logic        mem_rdata_v_i, mem_rdata_ready_o, mem_wdata_v_o, mem_wdata_yumi_i;

  logic [31:0] seed_r;
  word_t       resp_mem [1 << 14];
  word_t       ref_mem  [1 << 14];
  logic        dirty_blk [1 << 12];
  logic        pend_we   [$];
  addr_t       pend_addr [$];
  word_t       store_data [$];
  int          stall_pct;
  logic        held_r;
  word_t       held_data_r;
  int          mode_r;
  int          beat_r;
  block_addr_t blk_r;
  int          wb_count;

  cache_top i_cache_top (.*);

  function automatic logic [31:0] lcg(input logic [31:0] x);
    return x * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [31:0] rand_next();
    seed_r = lcg(seed_r);
    return seed_r >> 8;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("error t=%0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_block_addr(input string name, input block_addr_t got,
                                  input block_addr_t exp);
    if (got !== exp) begin
      fail_run($sformatf("error t=%0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // memory responder that stalls about one beat in four
  always @(negedge clk_i) begin
    logic [31:0] r;
    logic        go;
    mem_cmd_yumi_i   = 1'b0;
    mem_rdata_v_i    = 1'b0;
    mem_wdata_yumi_i = 1'b0;
    if (!reset_i) begin
      r  = rand_next();
      go = (r[1:0] != 2'b00);
      if (mode_r == 0 && mem_cmd_v_o && go) begin
        mem_cmd_yumi_i = 1'b1;
        blk_r  = mem_cmd_addr_o;
        beat_r = 0;
        if (pend_addr.size() == 0) begin
          fail_run("memory command with no request outstanding");
        end
        if (mem_cmd_write_o) begin
          if (!dirty_blk[mem_cmd_addr_o]) begin
            fail_run("write-back of a block that holds no stored data");
          end
          if (mem_cmd_addr_o[index_width_c-1:0]
              !== pend_addr[0][index_lsb_c +: index_width_c]) begin
            fail_run("write-back block is in a different set than the missing request");
          end
          dirty_blk[mem_cmd_addr_o] = 1'b0;
          wb_count++;
          mode_r = 1;
        end else begin
          check_block_addr("mem_cmd_addr_o", mem_cmd_addr_o,
                           pend_addr[0][addr_width_c-1:index_lsb_c]);
          mode_r = 2;
        end
      end else if (mode_r == 1 && mem_wdata_v_o && go) begin
        mem_wdata_yumi_i = 1'b1;
        check_word("mem_wdata_o", mem_wdata_o, ref_mem[{blk_r, 2'(beat_r)}]);
        resp_mem[{blk_r, 2'(beat_r)}] = mem_wdata_o;
        beat_r++;
        if (beat_r == words_per_block_c) mode_r = 0;
      end else if (mode_r == 2 && go) begin
        mem_rdata_v_i = 1'b1;
        mem_rdata_i   = resp_mem[{blk_r, 2'(beat_r)}];
        if (mem_rdata_ready_o) begin
          beat_r++;
          if (beat_r == words_per_block_c) mode_r = 0;
        end
      end
    end
  end

  // response side with random back-pressure and in-order checks
  always @(negedge clk_i) begin
    logic [31:0] r;
    logic        we;
    addr_t       a;
    word_t       d;
    if (!reset_i) begin
      r      = rand_next();
      yumi_i = ((r % 100) >= 32'(stall_pct));
      #1;
      if (held_r) begin
        if (!v_o) fail_run("v_o dropped before the response was taken");
        check_word("data_o", data_o, held_data_r);
      end
      held_r = 1'b0;
      if (v_o) begin
        if (pend_we.size() == 0) fail_run("response with no request outstanding");
        if (yumi_i) begin
          we = pend_we.pop_front();
          a  = pend_addr.pop_front();
          d  = store_data.pop_front();
          if (we) begin
            check_word("data_o", data_o, '0);
            ref_mem[a[addr_width_c-1:2]] = d;
            dirty_blk[a[addr_width_c-1:index_lsb_c]] = 1'b1;
          end else begin
            check_word("data_o", data_o, ref_mem[a[addr_width_c-1:2]]);
          end
        end else begin
          held_r      = 1'b1;
          held_data_r = data_o;
        end
      end
    end
  end

  // drives one request from a falling edge and returns at the next one
  task automatic issue(input logic we, input addr_t a, input word_t d);
    int n;
    v_i     = 1'b1;
    we_i    = we;
    addr_i  = a;
    wdata_i = d;
    n = 0;
    #1;
    while (!yumi_o) begin
      n++;
      if (n > timeout_c) begin
        fail_run($sformatf("timeout waiting for yumi_o, miss state %s",
                           i_cache_top.i_verify_stage.state_r.name()));
      end
      @(negedge clk_i);
      #1;
    end
    pend_we.push_back(we);
    pend_addr.push_back(a);
    store_data.push_back(d);
    @(negedge clk_i);
    v_i = 1'b0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (pend_we.size() != 0) begin
      n++;
      if (n > timeout_c) begin
        fail_run($sformatf("timeout waiting for responses, miss state %s",
                           i_cache_top.i_verify_stage.state_r.name()));
      end
      @(negedge clk_i);
    end
  endtask

  function automatic addr_t make_addr(input int tag, input int idx, input int off);
    return addr_t'((tag << tag_lsb_c) | (idx << index_lsb_c) | (off << word_off_lsb_c));
  endfunction

  initial begin
    logic [31:0] r;
    seed_r = 32'd87;
    reset_i = 1'b1;
    v_i = 1'b0;
    we_i = 1'b0;
    addr_i = '0;
    wdata_i = '0;
    yumi_i = 1'b0;
    mem_cmd_yumi_i = 1'b0;
    mem_rdata_v_i = 1'b0;
    mem_rdata_i = '0;
    mem_wdata_yumi_i = 1'b0;
    stall_pct = 20;
    held_r = 1'b0;
    mode_r = 0;
    wb_count = 0;
    for (int i = 0; i < (1 << 14); i++) begin
      resp_mem[i] = lcg(32'(i));
      ref_mem[i]  = lcg(32'(i));
    end
    for (int i = 0; i < (1 << 12); i++) dirty_blk[i] = 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    // untouched address
    issue(1'b0, 16'h1234, '0);
    drain();
    // store then loads right behind it and of its neighbors
    issue(1'b1, make_addr(2, 4, 1), 32'hcafe_0001);
    issue(1'b0, make_addr(2, 4, 1), '0);
    issue(1'b0, make_addr(2, 4, 0), '0);
    issue(1'b0, make_addr(2, 4, 2), '0);
    drain();
    // three tags on one set force dirty evictions
    for (int t = 1; t <= 3; t++) issue(1'b1, make_addr(t, 5, t), lcg(32'(t) + 32'd99));
    for (int t = 1; t <= 3; t++) issue(1'b0, make_addr(t, 5, t), '0);
    drain();
    if (wb_count == 0) fail_run("no dirty write-back seen for three tags in one set");
    // long back-pressure stretches
    stall_pct = 75;
    for (int i = 0; i < 60; i++) begin
      r = rand_next();
      issue(r[0], make_addr(int'(r[3:1]), int'(r[5:4]), int'(r[7:6])), rand_next());
    end
    drain();
    // random mix over four sets
    stall_pct = 30;
    for (int i = 0; i < 2000; i++) begin
      r = rand_next();
      issue(r[0], make_addr(int'(r[3:1]), int'(r[5:4]), int'(r[7:6])), rand_next());
      if (r[10:8] == 3'd0) @(negedge clk_i);
    end
    drain();
    $display("sim passed");
    $finish;
  end

endmodule

// ==== project.f ====
rtl/cache_pkg.sv
rtl/cache_tag_array.sv
rtl/cache_data_array.sv
rtl/cache_verify_stage.sv
rtl/cache_top.sv
dv/cache_tb.sv

// ==== rtl/cache_data_array.sv ====
// single-port data storage, both ways side by side in one row per word
// a write touches only the selected way; output holds the last read
`timescale 1ns/1ps

module cache_data_array (
  input  logic                                      clk_i,
  input  logic                                      rd_v_i,
  input  logic                                      wr_v_i,
  input  cache_pkg::index_t                         index_i,
  input  cache_pkg::word_off_t                      word_off_i,
  input  cache_pkg::way_t                           way_i,
  input  cache_pkg::word_t                          wdata_i,
  output cache_pkg::word_t [cache_pkg::ways_c-1:0]  rdata_o
);
  import cache_pkg::*;

  word_t [ways_c-1:0] mem [data_depth_c];

  logic [index_width_c+word_off_width_c-1:0] row;

  // row address is set index then word within the block
  assign row = {index_i, word_off_i};

  always_ff @(posedge clk_i) begin
    if (wr_v_i) begin
      mem[row][way_i] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_v_i) begin
      rdata_o <= mem[row];
    end
  end

endmodule

// ==== rtl/cache_pkg.sv ====
// shared widths and types for the 2-way write-back data cache
// full 32-bit words only; the two low address bits are ignored
// address layout from low to high is byte, word offset, index, tag
package cache_pkg;

  localparam int addr_width_c       = 16;
  localparam int data_width_c       = 32;
  localparam int words_per_block_c  = 4;
  localparam int sets_c             = 16;
  localparam int ways_c             = 2;

  localparam int byte_off_width_c   = 2;
  localparam int word_off_width_c   = $clog2(words_per_block_c);
  localparam int index_width_c      = $clog2(sets_c);
  localparam int tag_width_c        = addr_width_c - index_width_c - word_off_width_c
                                      - byte_off_width_c;
  localparam int block_addr_width_c = tag_width_c + index_width_c;

  // lsb position of each address field
  localparam int word_off_lsb_c     = byte_off_width_c;
  localparam int index_lsb_c        = word_off_lsb_c + word_off_width_c;
  localparam int tag_lsb_c          = index_lsb_c + index_width_c;

  // data array depth, one row per word of every set
  localparam int data_depth_c       = sets_c * words_per_block_c;

  typedef logic [addr_width_c-1:0]       addr_t;
  typedef logic [data_width_c-1:0]       word_t;
  typedef logic [tag_width_c-1:0]        tag_t;
  typedef logic [index_width_c-1:0]      index_t;
  typedef logic [word_off_width_c-1:0]   word_off_t;
  typedef logic [$clog2(ways_c)-1:0]     way_t;
  typedef logic [block_addr_width_c-1:0] block_addr_t;

  typedef enum logic [2:0] {
    idle,
    send_wb,
    wb_data,
    send_fill,
    fill_data,
    done
  } miss_state_e;

endpackage

// ==== rtl/cache_tag_array.sv ====
// tag, valid, dirty and LRU storage, one entry per set
// clears valid, dirty and LRU over sets_c cycles after reset and
// ignores writes until that walk is over; reads are read-first
`timescale 1ns/1ps

module cache_tag_array (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  input  logic                                        rd_v_i,
  input  cache_pkg::index_t                           rd_index_i,
  input  logic                                        wr_v_i,
  input  cache_pkg::index_t                           wr_index_i,
  input  cache_pkg::way_t                             wr_way_i,
  input  cache_pkg::tag_t                             wr_tag_i,
  input  logic                                        wr_valid_i,
  input  logic                                        wr_dirty_i,
  input  logic                                        wr_tag_en_i,
  input  cache_pkg::way_t                             wr_lru_i,
  output cache_pkg::tag_t [cache_pkg::ways_c-1:0]     tag_o,
  output logic [cache_pkg::ways_c-1:0]                valid_o,
  output logic [cache_pkg::ways_c-1:0]                dirty_o,
  output cache_pkg::way_t                             lru_o
);
  import cache_pkg::*;

  tag_t [ways_c-1:0] tag_mem   [sets_c];
  logic [ways_c-1:0] valid_mem [sets_c];
  logic [ways_c-1:0] dirty_mem [sets_c];
  way_t              lru_mem   [sets_c];

  index_t clr_index_r;
  logic   clearing_r;

  // reset walk over all sets
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      clr_index_r <= '0;
      clearing_r  <= 1'b1;
    end else if (clearing_r) begin
      clr_index_r <= clr_index_r + 1'b1;
      if (clr_index_r == index_t'(sets_c - 1)) begin
        clearing_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (clearing_r) begin
      valid_mem[clr_index_r] <= '0;
      dirty_mem[clr_index_r] <= '0;
      lru_mem[clr_index_r]   <= '0;
    end else if (wr_v_i) begin
      dirty_mem[wr_index_i][wr_way_i] <= wr_dirty_i;
      // stored bit names the victim, the way opposite the one just used
      lru_mem[wr_index_i] <= ~wr_lru_i;
      if (wr_tag_en_i) begin
        tag_mem[wr_index_i][wr_way_i]   <= wr_tag_i;
        valid_mem[wr_index_i][wr_way_i] <= wr_valid_i;
      end
    end
  end

  // registered read, held until the next read
  always_ff @(posedge clk_i) begin
    if (rd_v_i) begin
      tag_o   <= tag_mem[rd_index_i];
      valid_o <= valid_mem[rd_index_i];
      dirty_o <= dirty_mem[rd_index_i];
      lru_o   <= lru_mem[rd_index_i];
    end
  end

endmodule

// ==== rtl/cache_top.sv ====
// two-stage 2-way write-back cache, full-word loads and stores only
// requests are refused for sets_c cycles after reset while the tags clear
// a retired store or a finished refill costs one replay cycle in TL
`timescale 1ns/1ps

module cache_top (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     v_i,
  input  logic                     we_i,
  input  cache_pkg::addr_t         addr_i,
  input  cache_pkg::word_t         wdata_i,
  output logic                     yumi_o,
  output logic                     v_o,
  output cache_pkg::word_t         data_o,
  input  logic                     yumi_i,
  output logic                     mem_cmd_v_o,
  output logic                     mem_cmd_write_o,
  output cache_pkg::block_addr_t   mem_cmd_addr_o,
  input  logic                     mem_cmd_yumi_i,
  input  logic                     mem_rdata_v_i,
  input  cache_pkg::word_t         mem_rdata_i,
  output logic                     mem_rdata_ready_o,
  output logic                     mem_wdata_v_o,
  output cache_pkg::word_t         mem_wdata_o,
  input  logic                     mem_wdata_yumi_i
);
  import cache_pkg::*;

  index_t walk_cnt_r;
  logic   walk_done_r;
  logic   replay_r;

  logic  v_tl_r, we_tl_r;
  addr_t addr_tl_r;
  word_t wdata_tl_r;

  logic               v_tv_r, we_tv_r;
  addr_t              addr_tv_r;
  word_t              wdata_tv_r;
  tag_t [ways_c-1:0]  tag_tv_r;
  logic [ways_c-1:0]  valid_tv_r, dirty_tv_r;
  way_t               lru_tv_r;
  word_t [ways_c-1:0] rdata_tv_r;

  tag_t [ways_c-1:0]  arr_tag;
  logic [ways_c-1:0]  arr_valid, arr_dirty;
  way_t               arr_lru;
  word_t [ways_c-1:0] arr_rdata;
  word_t [ways_c-1:0] vs_rdata;

  way_t      vs_hit_way;
  logic      vs_miss_v, vs_miss_done, vs_tag_wr_v, vs_data_rd_v, vs_data_wr_v;
  word_off_t vs_word_off;
  word_t     vs_wdata;

  index_t    idx_in, idx_tl, idx_tv, da_index;
  word_off_t off_in, off_tl, off_tv, da_off;
  logic      retire, store_ret, tv_free, tl_adv, miss_busy, rd_replay, rd_new;

  assign idx_in = addr_i[index_lsb_c +: index_width_c];
  assign idx_tl = addr_tl_r[index_lsb_c +: index_width_c];
  assign idx_tv = addr_tv_r[index_lsb_c +: index_width_c];
  assign off_in = addr_i[word_off_lsb_c +: word_off_width_c];
  assign off_tl = addr_tl_r[word_off_lsb_c +: word_off_width_c];
  assign off_tv = addr_tv_r[word_off_lsb_c +: word_off_width_c];

  assign retire    = v_o & yumi_i;
  assign store_ret = retire & we_tv_r;
  // TL holds on a store or miss retirement so it can replay first
  assign tv_free   = ~v_tv_r | (retire & ~we_tv_r & ~vs_miss_v);
  assign tl_adv    = v_tl_r & ~replay_r & tv_free;
  assign miss_busy = vs_miss_v & ~vs_miss_done;
  assign rd_replay = replay_r & v_tl_r;
  assign rd_new    = yumi_o;

  assign yumi_o = v_i & walk_done_r & ~replay_r & ~miss_busy & ~store_ret
                  & (~v_tl_r | tl_adv);
  assign v_o    = v_tv_r & ~replay_r & (~vs_miss_v | vs_miss_done);

  // miss streaming needs the live array output instead of the TV copy
  assign vs_rdata = vs_miss_v ? arr_rdata : rdata_tv_r;

  // data array port, miss traffic first, then replay, store, new read
  always_comb begin
    if (vs_data_rd_v | vs_data_wr_v) begin
      da_index = idx_tv;
      da_off   = vs_word_off;
    end else if (rd_replay) begin
      da_index = idx_tl;
      da_off   = off_tl;
    end else if (store_ret) begin
      da_index = idx_tv;
      da_off   = off_tv;
    end else begin
      da_index = idx_in;
      da_off   = off_in;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      walk_cnt_r  <= '0;
      walk_done_r <= 1'b0;
      replay_r    <= 1'b0;
      v_tl_r      <= 1'b0;
      v_tv_r      <= 1'b0;
    end else begin
      if (!walk_done_r) begin
        walk_cnt_r <= walk_cnt_r + 1'b1;
        if (walk_cnt_r == index_t'(sets_c - 1)) begin
          walk_done_r <= 1'b1;
        end
      end
      replay_r <= store_ret | vs_tag_wr_v;
      if (yumi_o) begin
        v_tl_r <= 1'b1;
      end else if (tl_adv) begin
        v_tl_r <= 1'b0;
      end
      if (tl_adv) begin
        v_tv_r <= 1'b1;
      end else if (retire) begin
        v_tv_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (yumi_o) begin
      we_tl_r    <= we_i;
      addr_tl_r  <= addr_i;
      wdata_tl_r <= wdata_i;
    end
    if (tl_adv) begin
      we_tv_r    <= we_tl_r;
      addr_tv_r  <= addr_tl_r;
      wdata_tv_r <= wdata_tl_r;
      tag_tv_r   <= arr_tag;
      valid_tv_r <= arr_valid;
      dirty_tv_r <= arr_dirty;
      lru_tv_r   <= arr_lru;
      rdata_tv_r <= arr_rdata;
    end
  end

  cache_tag_array i_tag_array (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .rd_v_i      (rd_replay | rd_new),
    .rd_index_i  (replay_r ? idx_tl : idx_in),
    .wr_v_i      (vs_tag_wr_v | retire),
    .wr_index_i  (idx_tv),
    .wr_way_i    (vs_hit_way),
    .wr_tag_i    (addr_tv_r[tag_lsb_c +: tag_width_c]),
    .wr_valid_i  (1'b1),
    // refill clears dirty, a store sets it, a hit load keeps it
    .wr_dirty_i  (~vs_tag_wr_v & (we_tv_r | (~vs_miss_v & dirty_tv_r[vs_hit_way]))),
    .wr_tag_en_i (vs_tag_wr_v),
    .wr_lru_i    (vs_hit_way),
    .tag_o       (arr_tag),
    .valid_o     (arr_valid),
    .dirty_o     (arr_dirty),
    .lru_o       (arr_lru)
  );

  cache_data_array i_data_array (
    .clk_i      (clk_i),
    .rd_v_i     (vs_data_rd_v | rd_replay | rd_new),
    .wr_v_i     (vs_data_wr_v | store_ret),
    .index_i    (da_index),
    .word_off_i (da_off),
    .way_i      (vs_hit_way),
    .wdata_i    (vs_data_wr_v ? vs_wdata : wdata_tv_r),
    .rdata_o    (arr_rdata)
  );

  cache_verify_stage i_verify_stage (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .tv_v_i            (v_tv_r),
    .tv_we_i           (we_tv_r),
    .tv_addr_i         (addr_tv_r),
    .tag_i             (tag_tv_r),
    .valid_i           (valid_tv_r),
    .dirty_i           (dirty_tv_r),
    .lru_i             (lru_tv_r),
    .rdata_i           (vs_rdata),
    .hit_way_o         (vs_hit_way),
    .miss_v_o          (vs_miss_v),
    .miss_done_o       (vs_miss_done),
    .load_data_o       (data_o),
    .tag_wr_v_o        (vs_tag_wr_v),
    .data_rd_v_o       (vs_data_rd_v),
    .data_wr_v_o       (vs_data_wr_v),
    .data_word_off_o   (vs_word_off),
    .data_wdata_o      (vs_wdata),
    .mem_cmd_v_o       (mem_cmd_v_o),
    .mem_cmd_write_o   (mem_cmd_write_o),
    .mem_cmd_addr_o    (mem_cmd_addr_o),
    .mem_cmd_yumi_i    (mem_cmd_yumi_i),
    .mem_rdata_v_i     (mem_rdata_v_i),
    .mem_rdata_i       (mem_rdata_i),
    .mem_rdata_ready_o (mem_rdata_ready_o),
    .mem_wdata_v_o     (mem_wdata_v_o),
    .mem_wdata_o       (mem_wdata_o),
    .mem_wdata_yumi_i  (mem_wdata_yumi_i)
  );

endmodule

// ==== rtl/cache_verify_stage.sv ====
// tag compare, hit word select and miss handling for the TV stage
// victim is the LRU way; a dirty victim is written back before the refill
// memory moves one word per beat, lowest word first
// stays in done until the TV slot empties
`timescale 1ns/1ps

module cache_verify_stage (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  logic                                      tv_v_i,
  input  logic                                      tv_we_i,
  input  cache_pkg::addr_t                          tv_addr_i,
  input  cache_pkg::tag_t [cache_pkg::ways_c-1:0]   tag_i,
  input  logic [cache_pkg::ways_c-1:0]              valid_i,
  input  logic [cache_pkg::ways_c-1:0]              dirty_i,
  input  cache_pkg::way_t                           lru_i,
  input  cache_pkg::word_t [cache_pkg::ways_c-1:0]  rdata_i,
  output cache_pkg::way_t                           hit_way_o,
  output logic                                      miss_v_o,
  output logic                                      miss_done_o,
  output cache_pkg::word_t                          load_data_o,
  output logic                                      tag_wr_v_o,
  output logic                                      data_rd_v_o,
  output logic                                      data_wr_v_o,
  output cache_pkg::word_off_t                      data_word_off_o,
  output cache_pkg::word_t                          data_wdata_o,
  output logic                                      mem_cmd_v_o,
  output logic                                      mem_cmd_write_o,
  output cache_pkg::block_addr_t                    mem_cmd_addr_o,
  input  logic                                      mem_cmd_yumi_i,
  input  logic                                      mem_rdata_v_i,
  input  cache_pkg::word_t                          mem_rdata_i,
  output logic                                      mem_rdata_ready_o,
  output logic                                      mem_wdata_v_o,
  output cache_pkg::word_t                          mem_wdata_o,
  input  logic                                      mem_wdata_yumi_i
);
  import cache_pkg::*;

  tag_t              tv_tag;
  index_t            tv_index;
  word_off_t         tv_off;
  logic [ways_c-1:0] hit_vec;
  logic              hit;
  way_t              hit_way;
  logic              last_beat;

  miss_state_e state_r;
  word_off_t   cnt_r;
  logic        wb_have_r;
  word_t       fill_word_r;

  assign tv_tag   = tv_addr_i[tag_lsb_c +: tag_width_c];
  assign tv_index = tv_addr_i[index_lsb_c +: index_width_c];
  assign tv_off   = tv_addr_i[word_off_lsb_c +: word_off_width_c];

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < ways_c; w++) begin
      hit_vec[w] = valid_i[w] & (tag_i[w] == tv_tag);
      if (hit_vec[w]) begin
        hit_way = way_t'(w);
      end
    end
  end

  assign hit = |hit_vec;

  // on a miss the request lands in the victim way
  assign hit_way_o   = hit ? hit_way : lru_i;
  assign miss_v_o    = tv_v_i & ~hit;
  assign miss_done_o = (state_r == done);
  // stores return zero
  assign load_data_o = tv_we_i ? '0 : (miss_done_o ? fill_word_r : rdata_i[hit_way]);

  assign mem_cmd_v_o     = (state_r == send_wb) | (state_r == send_fill);
  assign mem_cmd_write_o = (state_r == send_wb);
  assign mem_cmd_addr_o  = mem_cmd_write_o ? {tag_i[lru_i], tv_index} : {tv_tag, tv_index};

  // write-back alternates an array read with a memory beat
  assign data_rd_v_o   = (state_r == wb_data) & ~wb_have_r;
  assign mem_wdata_v_o = (state_r == wb_data) & wb_have_r;
  assign mem_wdata_o   = rdata_i[lru_i];

  assign mem_rdata_ready_o = (state_r == fill_data);
  assign data_wr_v_o       = mem_rdata_ready_o & mem_rdata_v_i;
  assign data_wdata_o      = mem_rdata_i;
  assign data_word_off_o   = cnt_r;
  assign last_beat         = (cnt_r == word_off_t'(words_per_block_c - 1));
  // new tag goes in with the last refill word
  assign tag_wr_v_o        = data_wr_v_o & last_beat;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r   <= idle;
      cnt_r     <= '0;
      wb_have_r <= 1'b0;
    end else begin
      case (state_r)
        idle: begin
          cnt_r     <= '0;
          wb_have_r <= 1'b0;
          if (miss_v_o) begin
            state_r <= (valid_i[lru_i] & dirty_i[lru_i]) ? send_wb : send_fill;
          end
        end
        send_wb: begin
          if (mem_cmd_yumi_i) begin
            state_r <= wb_data;
          end
        end
        wb_data: begin
          if (!wb_have_r) begin
            wb_have_r <= 1'b1;
          end else if (mem_wdata_yumi_i) begin
            wb_have_r <= 1'b0;
            cnt_r     <= cnt_r + 1'b1;
            if (last_beat) begin
              state_r <= send_fill;
            end
          end
        end
        send_fill: begin
          if (mem_cmd_yumi_i) begin
            state_r <= fill_data;
          end
        end
        fill_data: begin
          if (mem_rdata_v_i) begin
            cnt_r <= cnt_r + 1'b1;
            if (last_beat) begin
              state_r <= done;
            end
          end
        end
        done: begin
          if (!tv_v_i) begin
            state_r <= idle;
          end
        end
        default: state_r <= idle;
      endcase
    end
  end

  // requested word taken off the refill stream
  always_ff @(posedge clk_i) begin
    if (data_wr_v_o && (cnt_r == tv_off)) begin
      fill_word_r <= mem_rdata_i;
    end
  end

endmodule
